// File: logic/exe_pkg.sv
package exe_pkg;

    localparam int xlen     = 32;
    localparam int md_width = xlen + 1; // spare bit for the sign of unsigned operands

    typedef enum logic [4:0] {
        alu_add    = 5'd0,
        alu_sub    = 5'd1,
        alu_and    = 5'd2,
        alu_or     = 5'd3,
        alu_xor    = 5'd4,
        alu_sll    = 5'd5,
        alu_srl    = 5'd6,
        alu_sra    = 5'd7,
        alu_slt    = 5'd8,
        alu_sltu   = 5'd9,
        alu_jalr   = 5'd10,
        alu_copy1  = 5'd11,
        alu_mul    = 5'd12, // multicycle codes from here
        alu_mulh   = 5'd13,
        alu_mulhsu = 5'd14,
        alu_mulhu  = 5'd15,
        alu_div    = 5'd16,
        alu_divu   = 5'd17,
        alu_rem    = 5'd18,
        alu_remu   = 5'd19
    } alu_op_e;

    // branch codes sit above the alu codes so one field can hold either
    typedef enum logic [4:0] {
        br_beq  = 5'd20,
        br_bne  = 5'd21,
        br_blt  = 5'd22,
        br_bge  = 5'd23,
        br_bltu = 5'd24,
        br_bgeu = 5'd25
    } br_op_e;

    typedef union packed {
        alu_op_e alu;
        br_op_e  br;
    } exe_fun_u;

endpackage

// File: logic/exe_latch.sv
`timescale 1ns/100ps

module exe_latch #(
    parameter int id_w = 64
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      flush,
    input  logic                      stall,

    input  logic                      in_valid,
    input  logic [exe_pkg::xlen-1:0]  in_pc,
    input  logic [id_w-1:0]           in_id,
    input  logic [4:0]                in_fun,
    input  logic [exe_pkg::xlen-1:0]  in_op1,
    input  logic [exe_pkg::xlen-1:0]  in_op2,
    input  logic [exe_pkg::xlen-1:0]  in_imm_b,

    output logic                      ex_valid,
    output logic [exe_pkg::xlen-1:0]  ex_pc,
    output logic [id_w-1:0]           ex_id,
    output logic [4:0]                ex_fun,
    output logic [exe_pkg::xlen-1:0]  ex_op1,
    output logic [exe_pkg::xlen-1:0]  ex_op2,
    output logic [exe_pkg::xlen-1:0]  ex_imm_b
);

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            ex_valid <= 1'b0; // kills the op in flight
        end else if (!stall) begin
            ex_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin // hold everything while the stage is busy
            ex_pc    <= in_pc;
            ex_id    <= in_id;
            ex_fun   <= in_fun;
            ex_op1   <= in_op1;
            ex_op2   <= in_op2;
            ex_imm_b <= in_imm_b;
        end
    end

endmodule

// File: logic/mul_unit.sv
`timescale 1ns/100ps

module mul_unit #(
    parameter int size = 33
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                abort,
    input  logic                start,
    input  logic [size-1:0]     a,
    input  logic [size-1:0]     b,
    output logic                busy,
    output logic                done,
    output logic [2*size-1:0]   product
);

    localparam int cnt_w = $clog2(size);

    logic [2*size-1:0] mcand_q;
    logic [2*size-1:0] acc_q;
    logic [2*size-1:0] acc_next;
    logic [size-1:0]   mplier_q;
    logic [cnt_w-1:0]  cnt_q;
    logic              last;

    assign last = cnt_q == cnt_w'(size - 1);

    always_comb begin
        acc_next = acc_q;
        if (mplier_q[0]) begin
            // top bit of the multiplier carries negative weight
            if (last) begin
                acc_next = acc_q - mcand_q;
            end else begin
                acc_next = acc_q + mcand_q;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || abort) begin
            busy <= 1'b0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start && !busy) begin
                busy <= 1'b1;
            end else if (busy && last) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start && !busy) begin
            mcand_q  <= {{size{a[size-1]}}, a}; // sign extend to full width
            mplier_q <= b;
            acc_q    <= '0;
            cnt_q    <= '0;
        end else if (busy) begin
            acc_q    <= acc_next;
            mcand_q  <= mcand_q << 1;
            mplier_q <= mplier_q >> 1;
            cnt_q    <= cnt_q + 1'b1;
        end
    end

    assign product = acc_q;

endmodule

// File: logic/div_unit.sv
`timescale 1ns/100ps

module div_unit #(
    parameter int size = 33
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              abort,
    input  logic              start,
    input  logic              is_signed,
    input  logic [size-1:0]   dividend,
    input  logic [size-1:0]   divisor,
    output logic              busy,
    output logic              done,
    output logic              div_zero,
    output logic [size-1:0]   quotient,
    output logic [size-1:0]   remainder
);

    localparam int cnt_w = $clog2(size);

    logic              dvd_neg;
    logic              dvs_neg;
    logic [size-1:0]   dvd_mag;
    logic [size-1:0]   dvs_mag;
    logic [size-1:0]   quo_q;
    logic [size-1:0]   rem_q;
    logic [size-1:0]   dvs_q;
    logic              q_neg_q;
    logic              r_neg_q;
    logic              zero_q;
    logic [cnt_w-1:0]  cnt_q;
    logic [size:0]     trial;
    logic              last;

    assign dvd_neg = is_signed && dividend[size-1];
    assign dvs_neg = is_signed && divisor[size-1];
    assign dvd_mag = dvd_neg ? -dividend : dividend;
    assign dvs_mag = dvs_neg ? -divisor : divisor;

    assign trial = {rem_q, quo_q[size-1]} - {1'b0, dvs_q}; // msb set means it did not fit
    assign last  = cnt_q == cnt_w'(size - 1);

    always_ff @(posedge clk) begin
        if (rst || abort) begin
            busy     <= 1'b0;
            done     <= 1'b0;
            div_zero <= 1'b0;
        end else begin
            done     <= 1'b0;
            div_zero <= 1'b0;
            if (start && !busy) begin
                busy <= 1'b1;
            end else if (busy && last) begin
                busy     <= 1'b0;
                done     <= 1'b1;
                div_zero <= zero_q;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start && !busy) begin
            quo_q   <= dvd_mag; // quotient bits shift in behind the dividend
            rem_q   <= '0;
            dvs_q   <= dvs_mag;
            q_neg_q <= dvd_neg ^ dvs_neg;
            r_neg_q <= dvd_neg;
            zero_q  <= divisor == '0;
            cnt_q   <= '0;
        end else if (busy) begin
            if (!trial[size]) begin
                rem_q <= trial[size-1:0];
                quo_q <= {quo_q[size-2:0], 1'b1};
            end else begin
                rem_q <= {rem_q[size-2:0], quo_q[size-1]}; // restore
                quo_q <= {quo_q[size-2:0], 1'b0};
            end
            cnt_q <= cnt_q + 1'b1;
        end
    end

    assign quotient  = q_neg_q ? -quo_q : quo_q;
    assign remainder = r_neg_q ? -rem_q : rem_q;

endmodule

// File: logic/exe_stage.sv
`timescale 1ns/100ps

module exe_stage #(
    parameter int id_w = 64
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      flush,

    input  logic                      ex_valid,
    input  logic [exe_pkg::xlen-1:0]  ex_pc,
    input  logic [id_w-1:0]           ex_id,
    input  logic [4:0]                ex_fun,
    input  logic [exe_pkg::xlen-1:0]  ex_op1,
    input  logic [exe_pkg::xlen-1:0]  ex_op2,
    input  logic [exe_pkg::xlen-1:0]  ex_imm_b,

    output logic                      stall,
    output logic                      mem_valid,
    output logic [exe_pkg::xlen-1:0]  mem_pc,
    output logic [id_w-1:0]           mem_id,
    output logic [exe_pkg::xlen-1:0]  mem_alu_out,
    output logic                      branch_taken,
    output logic [exe_pkg::xlen-1:0]  branch_target
);

    localparam int xl = exe_pkg::xlen;
    localparam int mw = exe_pkg::md_width;

    exe_pkg::exe_fun_u fun_u;

    logic              is_mul;
    logic              is_div;
    logic              is_multi;
    logic              div_signed;
    logic              started_q;   // unit kicked off for the op in the latch
    logic              calc_done_q; // result saved, op leaves at the next edge
    logic [xl-1:0]     alu_res;
    logic [xl-1:0]     md_res;
    logic [xl-1:0]     md_res_q;

    logic              mul_start;
    logic              mul_done;
    logic [mw-1:0]     mul_a;
    logic [mw-1:0]     mul_b;
    logic [2*mw-1:0]   product;

    logic              div_start;
    logic              div_done;
    logic              div_zero;
    logic [mw-1:0]     dvd;
    logic [mw-1:0]     dvs;
    logic [mw-1:0]     quotient;
    logic [mw-1:0]     remainder;

    assign fun_u = ex_fun;

    assign is_mul     = fun_u.alu inside {exe_pkg::alu_mul, exe_pkg::alu_mulh,
                                          exe_pkg::alu_mulhsu, exe_pkg::alu_mulhu};
    assign is_div     = fun_u.alu inside {exe_pkg::alu_div, exe_pkg::alu_divu,
                                          exe_pkg::alu_rem, exe_pkg::alu_remu};
    assign is_multi   = is_mul || is_div;
    assign div_signed = fun_u.alu inside {exe_pkg::alu_div, exe_pkg::alu_rem};

    // mulh and mulhsu take op1 as signed, only mulh takes op2 as signed
    assign mul_a = {ex_op1[xl-1] && fun_u.alu != exe_pkg::alu_mulhu, ex_op1};
    assign mul_b = {ex_op2[xl-1] && fun_u.alu == exe_pkg::alu_mulh, ex_op2};
    assign dvd   = {ex_op1[xl-1] && div_signed, ex_op1};
    assign dvs   = {ex_op2[xl-1] && div_signed, ex_op2};

    assign mul_start = ex_valid && is_mul && !started_q;
    assign div_start = ex_valid && is_div && !started_q;

    always_comb begin
        case (fun_u.alu)
            exe_pkg::alu_add:   alu_res = ex_op1 + ex_op2;
            exe_pkg::alu_sub:   alu_res = ex_op1 - ex_op2;
            exe_pkg::alu_and:   alu_res = ex_op1 & ex_op2;
            exe_pkg::alu_or:    alu_res = ex_op1 | ex_op2;
            exe_pkg::alu_xor:   alu_res = ex_op1 ^ ex_op2;
            exe_pkg::alu_sll:   alu_res = ex_op1 << ex_op2[4:0];
            exe_pkg::alu_srl:   alu_res = ex_op1 >> ex_op2[4:0];
            exe_pkg::alu_sra:   alu_res = $signed(ex_op1) >>> ex_op2[4:0];
            exe_pkg::alu_slt:   alu_res = {{(xl-1){1'b0}}, $signed(ex_op1) < $signed(ex_op2)};
            exe_pkg::alu_sltu:  alu_res = {{(xl-1){1'b0}}, ex_op1 < ex_op2};
            exe_pkg::alu_jalr:  alu_res = (ex_op1 + ex_op2) & {{(xl-1){1'b1}}, 1'b0};
            exe_pkg::alu_copy1: alu_res = ex_op1;
            default:            alu_res = '0;
        endcase
    end

    always_comb begin
        case (fun_u.br)
            exe_pkg::br_beq:  branch_taken = ex_op1 == ex_op2;
            exe_pkg::br_bne:  branch_taken = ex_op1 != ex_op2;
            exe_pkg::br_blt:  branch_taken = $signed(ex_op1) < $signed(ex_op2);
            exe_pkg::br_bge:  branch_taken = $signed(ex_op1) >= $signed(ex_op2);
            exe_pkg::br_bltu: branch_taken = ex_op1 < ex_op2;
            exe_pkg::br_bgeu: branch_taken = ex_op1 >= ex_op2;
            default:          branch_taken = 1'b0;
        endcase
    end

    always_comb begin
        case (fun_u.alu)
            exe_pkg::alu_mul:
                md_res = product[xl-1:0];
            exe_pkg::alu_mulh, exe_pkg::alu_mulhsu, exe_pkg::alu_mulhu:
                md_res = product[2*xl-1:xl];
            exe_pkg::alu_div, exe_pkg::alu_divu:
                md_res = div_zero ? '1 : quotient[xl-1:0];
            exe_pkg::alu_rem, exe_pkg::alu_remu:
                md_res = div_zero ? ex_op1 : remainder[xl-1:0];
            default:
                md_res = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            started_q   <= 1'b0;
            calc_done_q <= 1'b0;
        end else if (calc_done_q) begin
            started_q   <= 1'b0;
            calc_done_q <= 1'b0;
        end else begin
            if (mul_start || div_start) begin
                started_q <= 1'b1;
            end
            if (mul_done || div_done) begin
                calc_done_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mul_done || div_done) begin
            md_res_q <= md_res; // held until the op leaves
        end
    end

    assign stall         = ex_valid && is_multi && !calc_done_q;
    assign mem_valid     = ex_valid && (!is_multi || calc_done_q);
    assign mem_pc        = ex_pc;
    assign mem_id        = ex_id;
    assign mem_alu_out   = is_multi ? md_res_q : alu_res;
    assign branch_target = ex_pc + ex_imm_b;

    mul_unit #(
        .size(mw)
    ) i_mul (
        .clk     (clk),
        .rst     (rst),
        .abort   (flush),
        .start   (mul_start),
        .a       (mul_a),
        .b       (mul_b),
        .busy    (),
        .done    (mul_done),
        .product (product)
    );

    div_unit #(
        .size(mw)
    ) i_div (
        .clk       (clk),
        .rst       (rst),
        .abort     (flush),
        .start     (div_start),
        .is_signed (div_signed),
        .dividend  (dvd),
        .divisor   (dvs),
        .busy      (),
        .done      (div_done),
        .div_zero  (div_zero),
        .quotient  (quotient),
        .remainder (remainder)
    );

endmodule

// File: logic/exe_top.sv
`timescale 1ns/100ps

module exe_top #(
    parameter int id_w = 64
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      flush,

    input  logic                      issue_valid,
    input  logic [exe_pkg::xlen-1:0]  issue_pc,
    input  logic [id_w-1:0]           issue_id,
    input  logic [4:0]                issue_fun,
    input  logic [exe_pkg::xlen-1:0]  issue_op1,
    input  logic [exe_pkg::xlen-1:0]  issue_op2,
    input  logic [exe_pkg::xlen-1:0]  issue_imm_b,

    output logic                      stall,
    output logic                      mem_valid,
    output logic [exe_pkg::xlen-1:0]  mem_pc,
    output logic [id_w-1:0]           mem_id,
    output logic [exe_pkg::xlen-1:0]  mem_alu_out,
    output logic                      branch_taken,
    output logic [exe_pkg::xlen-1:0]  branch_target
);

    logic                      ex_valid;
    logic [exe_pkg::xlen-1:0]  ex_pc;
    logic [id_w-1:0]           ex_id;
    logic [4:0]                ex_fun;
    logic [exe_pkg::xlen-1:0]  ex_op1;
    logic [exe_pkg::xlen-1:0]  ex_op2;
    logic [exe_pkg::xlen-1:0]  ex_imm_b;

    exe_latch #(
        .id_w(id_w)
    ) i_latch (
        .clk      (clk),
        .rst      (rst),
        .flush    (flush),
        .stall    (stall),
        .in_valid (issue_valid),
        .in_pc    (issue_pc),
        .in_id    (issue_id),
        .in_fun   (issue_fun),
        .in_op1   (issue_op1),
        .in_op2   (issue_op2),
        .in_imm_b (issue_imm_b),
        .ex_valid (ex_valid),
        .ex_pc    (ex_pc),
        .ex_id    (ex_id),
        .ex_fun   (ex_fun),
        .ex_op1   (ex_op1),
        .ex_op2   (ex_op2),
        .ex_imm_b (ex_imm_b)
    );

    exe_stage #(
        .id_w(id_w)
    ) i_stage (
        .clk           (clk),
        .rst           (rst),
        .flush         (flush),
        .ex_valid      (ex_valid),
        .ex_pc         (ex_pc),
        .ex_id         (ex_id),
        .ex_fun        (ex_fun),
        .ex_op1        (ex_op1),
        .ex_op2        (ex_op2),
        .ex_imm_b      (ex_imm_b),
        .stall         (stall),
        .mem_valid     (mem_valid),
        .mem_pc        (mem_pc),
        .mem_id        (mem_id),
        .mem_alu_out   (mem_alu_out),
        .branch_taken  (branch_taken),
        .branch_target (branch_target)
    );

endmodule

// File: tests/exe_tb.sv
`timescale 1ns/100ps

module exe_tb;

    localparam int n_ops       = 90;
    localparam int cycle_limit = n_ops * 40 + 500; // worst case about 35 cycles per op

    typedef struct {
        logic [31:0] res;
        logic        taken;
        logic [31:0] target;
        logic [31:0] pc;
        logic [63:0] id;
        bit          multi;
        bit          is_br;
        int          cyc;
    } exp_t;

    logic        clk;
    logic        rst;
    logic        flush;
    logic        issue_valid;
    logic [31:0] issue_pc;
    logic [63:0] issue_id;
    logic [4:0]  issue_fun;
    logic [31:0] issue_op1;
    logic [31:0] issue_op2;
    logic [31:0] issue_imm_b;
    logic        stall;
    logic        mem_valid;
    logic [31:0] mem_pc;
    logic [63:0] mem_id;
    logic [31:0] mem_alu_out;
    logic        branch_taken;
    logic [31:0] branch_target;

    exp_t  exp_q[$];
    exp_t  cur;
    int    cyc;
    int    stall_seen;
    int    errors;
    int    errs_at_start;
    int    checks;
    int    op_count;
    int    tests_run;
    int    tests_failed;
    string test_name;

    exe_top i_dut (
        .clk           (clk),
        .rst           (rst),
        .flush         (flush),
        .issue_valid   (issue_valid),
        .issue_pc      (issue_pc),
        .issue_id      (issue_id),
        .issue_fun     (issue_fun),
        .issue_op1     (issue_op1),
        .issue_op2     (issue_op2),
        .issue_imm_b   (issue_imm_b),
        .stall         (stall),
        .mem_valid     (mem_valid),
        .mem_pc        (mem_pc),
        .mem_id        (mem_id),
        .mem_alu_out   (mem_alu_out),
        .branch_taken  (branch_taken),
        .branch_target (branch_target)
    );

    always #50 clk = ~clk;

    // returns {taken, result} following the RV32IM rules
    function automatic logic [32:0] exe_model(input logic [4:0] fun, input logic [31:0] op1,
                                              input logic [31:0] op2);
        logic [63:0] prod;
        logic [31:0] res;
        logic        taken;
        res   = '0;
        taken = 1'b0;
        prod  = '0;
        case (fun)
            exe_pkg::alu_add:    res = op1 + op2;
            exe_pkg::alu_sub:    res = op1 - op2;
            exe_pkg::alu_and:    res = op1 & op2;
            exe_pkg::alu_or:     res = op1 | op2;
            exe_pkg::alu_xor:    res = op1 ^ op2;
            exe_pkg::alu_sll:    res = op1 << op2[4:0];
            exe_pkg::alu_srl:    res = op1 >> op2[4:0];
            exe_pkg::alu_sra:    res = $signed(op1) >>> op2[4:0];
            exe_pkg::alu_slt:    res = {31'b0, $signed(op1) < $signed(op2)};
            exe_pkg::alu_sltu:   res = {31'b0, op1 < op2};
            exe_pkg::alu_jalr:   res = (op1 + op2) & 32'hFFFF_FFFE;
            exe_pkg::alu_copy1:  res = op1;
            exe_pkg::alu_mul: begin
                prod = {32'b0, op1} * {32'b0, op2};
                res  = prod[31:0];
            end
            exe_pkg::alu_mulh: begin
                prod = {{32{op1[31]}}, op1} * {{32{op2[31]}}, op2};
                res  = prod[63:32];
            end
            exe_pkg::alu_mulhsu: begin
                prod = {{32{op1[31]}}, op1} * {32'b0, op2};
                res  = prod[63:32];
            end
            exe_pkg::alu_mulhu: begin
                prod = {32'b0, op1} * {32'b0, op2};
                res  = prod[63:32];
            end
            exe_pkg::alu_div: begin
                if (op2 == 0) res = 32'hFFFF_FFFF;
                else if (op1 == 32'h8000_0000 && op2 == 32'hFFFF_FFFF) res = op1;
                else res = $signed(op1) / $signed(op2);
            end
            exe_pkg::alu_divu:   res = (op2 == 0) ? 32'hFFFF_FFFF : op1 / op2;
            exe_pkg::alu_rem: begin
                if (op2 == 0) res = op1;
                else if (op1 == 32'h8000_0000 && op2 == 32'hFFFF_FFFF) res = '0;
                else res = $signed(op1) % $signed(op2);
            end
            exe_pkg::alu_remu:   res = (op2 == 0) ? op1 : op1 % op2;
            exe_pkg::br_beq:     taken = op1 == op2;
            exe_pkg::br_bne:     taken = op1 != op2;
            exe_pkg::br_blt:     taken = $signed(op1) < $signed(op2);
            exe_pkg::br_bge:     taken = $signed(op1) >= $signed(op2);
            exe_pkg::br_bltu:    taken = op1 < op2;
            exe_pkg::br_bgeu:    taken = op1 >= op2;
            default: ;
        endcase
        return {taken, res};
    endfunction

    function automatic logic [31:0] pick_operand();
        logic [31:0] r;
        r = $urandom();
        case ($urandom_range(7, 0))
            0: r = 32'h8000_0000;
            1: r = 32'hFFFF_FFFF;
            2: r = 32'h7FFF_FFFF;
            3: r = 32'h0000_0000;
            4: r = 32'h0000_0001;
            default: ;
        endcase
        return r;
    endfunction

    task automatic report_mismatch(input string field, input logic [63:0] exp_v,
                                   input logic [63:0] act_v);
        if (exp_v !== act_v) begin
            errors++;
            $display("MISMATCH %s %s expected %h actual %h", test_name, field, exp_v, act_v);
        end
    endtask

    task automatic check_entry(input exp_t e);
        report_mismatch("pc", e.pc, mem_pc);
        report_mismatch("id", e.id, mem_id);
        if (!e.is_br) report_mismatch("alu_out", e.res, mem_alu_out);
        report_mismatch("branch_taken", e.taken, branch_taken);
        report_mismatch("branch_target", e.target, branch_target);
        if (stall) begin
            errors++;
            $display("%s: stall is still high in the cycle of the result", test_name);
        end
        if (!e.multi && cyc - e.cyc != 1) begin
            errors++;
            $display("%s: single-cycle result came %0d cycles after acceptance",
                     test_name, cyc - e.cyc);
        end
        if (e.multi && (cyc - e.cyc < 2 || stall_seen == 0)) begin
            errors++;
            $display("%s: multicycle result came without a stall", test_name);
        end
    endtask

    // compare at the falling edge where outputs are settled
    always @(negedge clk) begin
        if (!rst) begin
            if (stall) stall_seen++;
            if (mem_valid) begin
                checks++;
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("%s: mem_valid came with no operation outstanding", test_name);
                end else begin
                    cur = exp_q.pop_front();
                    check_entry(cur);
                end
                stall_seen = 0;
            end
            if (flush) stall_seen = 0;
        end
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= cycle_limit) begin
            $display("timeout after %0d cycles, the DUT stopped producing results", cyc);
            $display("Test failures found");
            $finish;
        end
    end

    // called 10 ns after a rising edge, returns at the same phase
    task automatic issue_op(input logic [4:0] fun, input logic [31:0] op1,
                            input logic [31:0] op2, input bit expect_out);
        exp_t        e;
        logic [32:0] m;
        issue_valid = 1'b1;
        issue_fun   = fun;
        issue_op1   = op1;
        issue_op2   = op2;
        issue_pc    = $urandom() & 32'hFFFF_FFFC;
        issue_imm_b = $urandom() & 32'hFFFF_FFFE;
        issue_id    = {32'($urandom()), 32'(op_count)};
        m = exe_model(fun, op1, op2);
        e.res    = m[31:0];
        e.taken  = m[32];
        e.target = issue_pc + issue_imm_b;
        e.pc     = issue_pc;
        e.id     = issue_id;
        e.multi  = fun >= exe_pkg::alu_mul && fun <= exe_pkg::alu_remu;
        e.is_br  = fun >= exe_pkg::br_beq;
        @(negedge clk);
        while (stall) @(negedge clk); // held until the stage frees up
        e.cyc = cyc;
        @(posedge clk);
        if (expect_out) exp_q.push_back(e);
        op_count++;
        #10;
        issue_valid = 1'b0;
    endtask

    task automatic start_test(input string name);
        test_name     = name;
        errs_at_start = errors;
    endtask

    task automatic finish_test();
        while (exp_q.size() != 0) @(posedge clk);
        repeat (3) @(posedge clk);
        #10;
        tests_run++;
        if (errors == errs_at_start) begin
            $display("%s: ok", test_name);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", test_name, errors - errs_at_start);
        end
    endtask

    initial begin
        logic [31:0] a;
        logic [31:0] b;
        logic [4:0]  fun;
        void'($urandom(75));
        clk         = 1'b0;
        rst         = 1'b1;
        flush       = 1'b0;
        issue_valid = 1'b0;
        issue_pc    = '0;
        issue_id    = '0;
        issue_fun   = '0;
        issue_op1   = '0;
        issue_op2   = '0;
        issue_imm_b = '0;
        cyc         = 0;
        stall_seen  = 0;
        errors      = 0;
        checks      = 0;
        op_count    = 0;
        tests_run   = 0;
        tests_failed = 0;
        repeat (2) @(posedge clk);
        #10;
        rst = 1'b0;

        start_test("alu_back_to_back");
        for (int i = 0; i < 24; i++) begin
            issue_op(5'($urandom_range(11, 0)), $urandom(), $urandom(), 1'b1);
        end
        finish_test();

        start_test("branches");
        for (int i = 0; i < 18; i++) begin
            fun = 5'(exe_pkg::br_beq + i / 3);
            a = $urandom();
            b = $urandom();
            if (i % 3 == 1) b = a; // equal pair
            if (i % 3 == 2) begin
                a = 32'h8000_0000;
                b = 32'h7FFF_FFFF;
                if ($urandom_range(1, 0) == 1) begin
                    a = 32'h7FFF_FFFF;
                    b = 32'h8000_0000;
                end
            end
            issue_op(fun, a, b, 1'b1);
        end
        finish_test();

        start_test("multiply");
        for (int i = 0; i < 16; i++) begin
            fun = 5'(exe_pkg::alu_mul + i / 4);
            a = pick_operand();
            b = pick_operand();
            if (i % 4 == 0) begin
                a = 32'h8000_0000;
                b = 32'h8000_0000;
            end
            if (i % 4 == 1) begin
                a = 32'hFFFF_FFFF;
                b = 32'h8000_0000;
            end
            issue_op(fun, a, b, 1'b1);
        end
        finish_test();

        start_test("divide");
        for (int i = 0; i < 20; i++) begin
            fun = 5'(exe_pkg::alu_div + i / 5);
            a = pick_operand();
            b = pick_operand();
            if (i % 5 == 0) b = '0; // divide by zero
            if (i % 5 == 1) begin
                a = 32'h8000_0000;
                b = 32'hFFFF_FFFF;
            end
            issue_op(fun, a, b, 1'b1);
        end
        finish_test();

        start_test("held_under_stall");
        issue_op(exe_pkg::alu_mulhsu, $urandom(), $urandom(), 1'b1);
        for (int i = 0; i < 4; i++) begin
            issue_op(5'($urandom_range(11, 0)), $urandom(), $urandom(), 1'b1);
        end
        issue_op(exe_pkg::alu_rem, $urandom(), $urandom(), 1'b1);
        for (int i = 0; i < 2; i++) begin
            issue_op(5'($urandom_range(11, 0)), $urandom(), $urandom(), 1'b1);
        end
        finish_test();

        start_test("flush_divide");
        issue_op(exe_pkg::alu_div, $urandom(), 32'd7, 1'b0); // killed, no result expected
        repeat (4) @(posedge clk);
        #10;
        flush = 1'b1;
        @(posedge clk);
        #10;
        flush = 1'b0;
        issue_op(exe_pkg::alu_add, $urandom(), $urandom(), 1'b1);
        issue_op(exe_pkg::alu_divu, $urandom(), 32'd13, 1'b1);
        issue_op(exe_pkg::alu_mul, $urandom(), $urandom(), 1'b1);
        finish_test();

        $display("summary: %0d tests, %0d failed, %0d results checked, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: vlog.f
logic/exe_pkg.sv
logic/exe_latch.sv
logic/mul_unit.sv
logic/div_unit.sv
logic/exe_stage.sv
logic/exe_top.sv
tests/exe_tb.sv

// File: run_sim.sh
#!/bin/bash
# build and run the execute stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --top-module exe_tb -f vlog.f -o exe_sim \
    && ./obj_dir/exe_sim > sim.log 2>&1 \
    || echo "build or simulation run failed"

cat sim.log 2>/dev/null
grep -q 'All tests passed!' sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
